// ==== all.f ====
source/txn_pkg.sv
source/first_free_finder.sv
source/id_queue.sv
source/req_admit.sv
source/rsp_match.sv
source/txn_tracker_top.sv
verification/tb_txn_tracker.sv

// ==== run.sh ====
#!/bin/sh
# Build the tracker testbench with Verilator, run it and look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_txn_tracker -f all.f \
    && ./obj_dir/Vtb_txn_tracker | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }
grep -q '^>>> PASS$' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// ==== verification/tb_txn_tracker.sv ====
// Self-checking testbench for the transaction tracker; compile it with all.f and run tb_txn_tracker
`timescale 1ns/1ps

module tb_txn_tracker;

    import txn_pkg::*;

    localparam int CAPACITY       = 8;
    localparam int LINE_OFFSET    = 6;
    localparam int N_RAND         = 60;
    localparam int CYCLES_PER_TXN = 30;
    localparam int TXN_TOTAL      = CAPACITY + N_RAND + 1;
    localparam id_t MISS_ID       = 4'hf;

    logic    clk_i;
    logic    rst_ni;
    logic    up_req_valid_i;
    up_req_t up_req_i;
    logic    up_credit_o;
    logic    dn_req_valid_o;
    dn_req_t dn_req_o;
    logic    dn_rsp_valid_i;
    dn_rsp_t dn_rsp_i;
    logic    dn_rsp_ready_o;
    logic    up_rsp_valid_o;
    up_rsp_t up_rsp_o;

    // Per-ID model of outstanding addresses, oldest first
    addr_t       model_q [16][$];
    // Requests seen downstream and not yet answered, per ID
    int          issued [16];
    int          sent;
    int          returned;
    int          credits;
    int          err_req;
    int          err_rsp;
    int          err_flow;
    logic [31:0] lfsr;
    logic        rsp_en;
    logic        miss_req;
    logic        miss_sent;
    logic        taken;

    // Expected values, set by the stimulus and delayed to the cycle the DUT answers in
    dn_req_t exp_req_n, exp_req_q;
    up_rsp_t exp_rsp_n, exp_rsp_q;
    logic    exp_req_vld_q;
    logic    exp_rsp_vld_n, exp_rsp_vld_q;

    assign credits = CAPACITY - sent + returned;

    txn_tracker_top #(
        .CAPACITY    (CAPACITY),
        .LINE_OFFSET (LINE_OFFSET)
    ) uut (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .up_req_valid_i (up_req_valid_i),
        .up_req_i       (up_req_i),
        .up_credit_o    (up_credit_o),
        .dn_req_valid_o (dn_req_valid_o),
        .dn_req_o       (dn_req_o),
        .dn_rsp_valid_i (dn_rsp_valid_i),
        .dn_rsp_i       (dn_rsp_i),
        .dn_rsp_ready_o (dn_rsp_ready_o),
        .up_rsp_valid_o (up_rsp_valid_o),
        .up_rsp_o       (up_rsp_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            exp_req_vld_q <= 1'b0;
            exp_rsp_vld_q <= 1'b0;
        end else begin
            exp_req_vld_q <= up_req_valid_i;
            exp_rsp_vld_q <= exp_rsp_vld_n;
        end
    end

    always @(posedge clk_i) begin
        exp_req_q <= exp_req_n;
        exp_rsp_q <= exp_rsp_n;
    end

    // Galois LFSR, one step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // A line is outstanding when any modelled address shares the bits above the offset
    function automatic logic line_outstanding(input addr_t addr);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 16; i++) begin
            for (int j = 0; j < model_q[i].size(); j++) begin
                if ((model_q[i][j] >> LINE_OFFSET) == (addr >> LINE_OFFSET)) begin
                    hit = 1'b1;
                end
            end
        end
        return hit;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < 16; i++) begin
            n += model_q[i].size();
        end
        return n;
    endfunction

    // Downstream model, answers a random issued ID so that order only holds within one ID
    task automatic pick_response();
        logic [3:0] start;
        logic [3:0] idx;
        logic       found;
        found = 1'b0;
        start = 4'(rand_bits(4));
        if (miss_req && !miss_sent) begin
            dn_rsp_i       = '{id: MISS_ID, rdata: rand_bits(32)};
            dn_rsp_valid_i = 1'b1;
            miss_sent      = 1'b1;
        end else if (rsp_en && rand_bits(2) != 0) begin
            for (int k = 0; k < 16; k++) begin
                idx = start + 4'(k);
                if (!found && issued[idx] != 0) begin
                    found          = 1'b1;
                    dn_rsp_i       = '{id: idx, rdata: rand_bits(32)};
                    dn_rsp_valid_i = 1'b1;
                end
            end
        end
    endtask

    // One clock cycle: observe at the falling edge, drive just after the rising edge
    task automatic step();
        @(negedge clk_i);
        if (up_credit_o) returned++;
        if (dn_req_valid_o) issued[dn_req_o.id]++;
        if (dn_rsp_valid_i && dn_rsp_ready_o) begin
            exp_rsp_vld_n  = 1'b1;
            exp_rsp_n.id    = dn_rsp_i.id;
            exp_rsp_n.rdata = dn_rsp_i.rdata;
            exp_rsp_n.miss  = (model_q[dn_rsp_i.id].size() == 0);
            exp_rsp_n.addr  = '0;
            if (!exp_rsp_n.miss) begin
                exp_rsp_n.addr = model_q[dn_rsp_i.id].pop_front();
                issued[dn_rsp_i.id]--;
            end
            taken = 1'b1;
        end
        @(posedge clk_i);
        #1;
        exp_rsp_vld_n  = 1'b0;
        up_req_valid_i = 1'b0;
        if (taken) begin
            dn_rsp_valid_i = 1'b0;
            taken          = 1'b0;
        end
        if (!dn_rsp_valid_i) pick_response();
    endtask

    // Upstream master, sends only while it holds a credit
    task automatic send_req(input id_t id, input addr_t addr);
        while (credits == 0) step();
        exp_req_n = '{id: id, addr: addr, hazard: line_outstanding(addr)};
        model_q[id].push_back(addr);
        sent++;
        up_req_i       = '{id: id, addr: addr};
        up_req_valid_i = 1'b1;
        step();
    endtask

    task automatic wait_drain();
        while (credits != CAPACITY || pending() != 0) step();
    endtask

    a_reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !dn_req_valid_o && !up_rsp_valid_o && !up_credit_o)
        else begin
            err_flow++;
            $display("Outputs of the tracker are active while reset is held");
        end

    a_req_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dn_req_valid_o == exp_req_vld_q)
        else begin
            err_req++;
            $display("ERR req_forward exp=%0b act=%0b",
                     $sampled(exp_req_vld_q), $sampled(dn_req_valid_o));
        end

    a_req_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_req_vld_q |-> dn_req_o.id == exp_req_q.id && dn_req_o.addr == exp_req_q.addr)
        else begin
            err_req++;
            $display("ERR req_fields exp=%h act=%h", $sampled(exp_req_q), $sampled(dn_req_o));
        end

    a_hazard: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_req_vld_q |-> dn_req_o.hazard == exp_req_q.hazard)
        else begin
            err_req++;
            $display("ERR hazard exp=%0b act=%0b",
                     $sampled(exp_req_q.hazard), $sampled(dn_req_o.hazard));
        end

    a_rsp_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
        up_rsp_valid_o == exp_rsp_vld_q)
        else begin
            err_rsp++;
            $display("ERR rsp_valid exp=%0b act=%0b",
                     $sampled(exp_rsp_vld_q), $sampled(up_rsp_valid_o));
        end

    // Covers the paired address, the read data and the miss flag in one compare
    a_rsp_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
        exp_rsp_vld_q |-> up_rsp_o == exp_rsp_q)
        else begin
            err_rsp++;
            $display("ERR rsp_fields exp=%h act=%h", $sampled(exp_rsp_q), $sampled(up_rsp_o));
        end

    a_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        up_credit_o == (exp_rsp_vld_q && !exp_rsp_q.miss))
        else begin
            err_flow++;
            $display("ERR credit_pulse exp=%0b act=%0b",
                     $sampled(exp_rsp_vld_q && !exp_rsp_q.miss), $sampled(up_credit_o));
        end

    // Ready drops only in a cycle with an accepted request and is high in every other one
    a_ready_on_push: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dn_rsp_ready_o == !up_req_valid_i)
        else begin
            err_flow++;
            $display("ERR rsp_ready exp=%0b act=%0b",
                     $sampled(!up_req_valid_i), $sampled(dn_rsp_ready_o));
        end

    a_credit_bound: assert property (@(posedge clk_i) credits <= CAPACITY)
        else begin
            err_flow++;
            $display("Upstream credit count rose above the queue capacity");
        end

    initial begin : watchdog
        #((TXN_TOTAL * CYCLES_PER_TXN + 10) * 100);
        $display("Watchdog expired before all transactions completed");
        $display(">>> FAIL");
        $finish;
    end

    initial begin : main
        int total;
        up_req_valid_i = 1'b0;
        up_req_i       = '0;
        dn_rsp_valid_i = 1'b0;
        dn_rsp_i       = '0;
        rst_ni         = 1'b0;
        lfsr           = 32'h24a5;
        sent           = 0;
        returned       = 0;
        err_req        = 0;
        err_rsp        = 0;
        err_flow       = 0;
        rsp_en         = 1'b0;
        miss_req       = 1'b0;
        miss_sent      = 1'b0;
        taken          = 1'b0;
        exp_req_n      = '0;
        exp_rsp_n      = '0;
        exp_rsp_vld_n  = 1'b0;
        for (int i = 0; i < 16; i++) issued[i] = 0;
        repeat (5) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        step();

        // Fill every entry with downstream silent, then let it drain
        for (int n = 0; n < CAPACITY; n++) begin
            send_req(id_t'(rand_bits(3)), addr_t'(rand_bits(9)));
        end
        assert (credits == 0)
            else begin
                err_flow++;
                $display("ERR fill_credits exp=0 act=%0d", credits);
            end
        rsp_en = 1'b1;
        wait_drain();

        // Few lines and IDs so that hazards, same-ID chains and held responses are common
        for (int n = 0; n < N_RAND; n++) begin
            if (rand_bits(2) == 0) step();
            send_req(id_t'(rand_bits(3)),
                     (addr_t'(rand_bits(3)) << LINE_OFFSET) | addr_t'(rand_bits(LINE_OFFSET)));
        end
        wait_drain();

        // A response for an ID with nothing outstanding
        miss_req = 1'b1;
        while (!(miss_sent && !dn_rsp_valid_i)) step();
        repeat (4) step();
        assert (credits == CAPACITY)
            else begin
                err_flow++;
                $display("ERR credit_return exp=%0d act=%0d", CAPACITY, credits);
            end

        total = err_req + err_rsp + err_flow;
        $display("Errors: request %0d, response %0d, flow %0d", err_req, err_rsp, err_flow);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== source/txn_tracker_top.sv ====
// Top level of the outstanding-transaction tracker; connects admission, matching and the ID queue
`timescale 1ns/1ps

module txn_tracker_top #(
    parameter int CAPACITY    = 8,
    parameter int LINE_OFFSET = 6
) (
    input  logic             clk_i,
    input  logic             rst_ni,

    input  logic             up_req_valid_i,
    input  txn_pkg::up_req_t up_req_i,
    output logic             up_credit_o,

    output logic             dn_req_valid_o,
    output txn_pkg::dn_req_t dn_req_o,

    input  logic             dn_rsp_valid_i,
    input  txn_pkg::dn_rsp_t dn_rsp_i,
    output logic             dn_rsp_ready_o,

    output logic             up_rsp_valid_o,
    output txn_pkg::up_rsp_t up_rsp_o
);

    import txn_pkg::*;

    // Push port, driven by admission
    logic  push;
    id_t   push_id;
    addr_t push_addr;
    logic  push_gnt;

    // Line search port, driven by admission
    logic  search;
    addr_t search_addr;
    addr_t search_mask;
    logic  search_hit;

    // Popping lookup port, driven by matching
    logic  lookup;
    id_t   lookup_id;
    logic  lookup_gnt;
    addr_t lookup_addr;
    logic  lookup_hit;

    req_admit #(
        .LINE_OFFSET (LINE_OFFSET)
    ) i_req_admit (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .up_req_valid_i  (up_req_valid_i),
        .up_req_i        (up_req_i),
        .dn_req_valid_o  (dn_req_valid_o),
        .dn_req_o        (dn_req_o),
        .q_push_o        (push),
        .q_push_id_o     (push_id),
        .q_push_addr_o   (push_addr),
        .q_push_gnt_i    (push_gnt),
        .q_search_o      (search),
        .q_search_addr_o (search_addr),
        .q_search_mask_o (search_mask),
        .q_hit_i         (search_hit)
    );

    rsp_match i_rsp_match (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .dn_rsp_valid_i (dn_rsp_valid_i),
        .dn_rsp_i       (dn_rsp_i),
        .dn_rsp_ready_o (dn_rsp_ready_o),
        .q_lookup_o     (lookup),
        .q_lookup_id_o  (lookup_id),
        .q_gnt_i        (lookup_gnt),
        .q_addr_i       (lookup_addr),
        .q_hit_i        (lookup_hit),
        .up_rsp_valid_o (up_rsp_valid_o),
        .up_rsp_o       (up_rsp_o),
        .up_credit_o    (up_credit_o)
    );

    // Every lookup from the response side removes the entry it finds
    // The search is answered in the cycle it is asked, so its grant is left open
    id_queue #(
        .CAPACITY (CAPACITY),
        .ID_WIDTH ($bits(id_t))
    ) i_id_queue (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .inp_id_i         (push_id),
        .inp_data_i       (push_addr),
        .inp_req_i        (push),
        .inp_gnt_o        (push_gnt),
        .exists_data_i    (search_addr),
        .exists_mask_i    (search_mask),
        .exists_req_i     (search),
        .exists_o         (search_hit),
        .exists_gnt_o     (),
        .oup_id_i         (lookup_id),
        .oup_pop_i        (1'b1),
        .oup_req_i        (lookup),
        .oup_data_o       (lookup_addr),
        .oup_data_valid_o (lookup_hit),
        .oup_gnt_o        (lookup_gnt)
    );

endmodule

// ==== source/rsp_match.sv ====
// Response matching; pairs each downstream response with its oldest request and returns a credit
`timescale 1ns/1ps

module rsp_match (
    input  logic             clk_i,
    input  logic             rst_ni,

    input  logic             dn_rsp_valid_i,
    input  txn_pkg::dn_rsp_t dn_rsp_i,
    output logic             dn_rsp_ready_o,

    output logic             q_lookup_o,
    output txn_pkg::id_t     q_lookup_id_o,
    input  logic             q_gnt_i,
    input  txn_pkg::addr_t   q_addr_i,
    input  logic             q_hit_i,

    output logic             up_rsp_valid_o,
    output txn_pkg::up_rsp_t up_rsp_o,
    output logic             up_credit_o
);

    import txn_pkg::*;

    logic    xfer;
    logic    up_rsp_valid_q;
    logic    up_credit_q;
    up_rsp_t up_rsp_q;

    // Each valid response asks the queue for the head entry of its ID
    assign q_lookup_o    = dn_rsp_valid_i;
    assign q_lookup_id_o = dn_rsp_i.id;

    // The queue refuses the lookup in a cycle with a push, so its grant is our ready
    assign dn_rsp_ready_o = q_gnt_i;
    assign xfer           = dn_rsp_valid_i && q_gnt_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            up_rsp_valid_q <= 1'b0;
            up_credit_q    <= 1'b0;
        end else begin
            up_rsp_valid_q <= xfer;
            // Only a freed entry gives the upstream a new credit
            up_credit_q    <= xfer && q_hit_i;
        end
    end

    // A response without outstanding request goes back with miss set and a zero address
    always_ff @(posedge clk_i) begin
        if (xfer) begin
            up_rsp_q <= '{
                id:    dn_rsp_i.id,
                addr:  q_hit_i ? q_addr_i : '0,
                rdata: dn_rsp_i.rdata,
                miss:  !q_hit_i
            };
        end
    end

    assign up_rsp_valid_o = up_rsp_valid_q;
    assign up_rsp_o       = up_rsp_q;
    assign up_credit_o    = up_credit_q;

    // A response held back by a push has to wait unchanged until it is taken
    a_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dn_rsp_valid_i && !dn_rsp_ready_o |=> dn_rsp_valid_i && $stable(dn_rsp_i))
        else $error("rsp_match downstream response dropped or changed while refused");

endmodule

// ==== source/req_admit.sv ====
// Request admission; records each credited upstream request in the queue and issues it downstream
`timescale 1ns/1ps

module req_admit #(
    parameter int LINE_OFFSET = 6
) (
    input  logic             clk_i,
    input  logic             rst_ni,

    input  logic             up_req_valid_i,
    input  txn_pkg::up_req_t up_req_i,

    output logic             dn_req_valid_o,
    output txn_pkg::dn_req_t dn_req_o,

    output logic             q_push_o,
    output txn_pkg::id_t     q_push_id_o,
    output txn_pkg::addr_t   q_push_addr_o,
    input  logic             q_push_gnt_i,

    output logic             q_search_o,
    output txn_pkg::addr_t   q_search_addr_o,
    output txn_pkg::addr_t   q_search_mask_o,
    input  logic             q_hit_i
);

    import txn_pkg::*;

    // Bits above the line offset identify a line, the offset bits within it are ignored
    localparam addr_t LINE_MASK = addr_t'('1) << LINE_OFFSET;

    logic    dn_req_valid_q;
    dn_req_t dn_req_q;

    // Every valid request is pushed, upstream only sends while it holds a credit
    assign q_push_o      = up_req_valid_i;
    assign q_push_id_o   = up_req_i.id;
    assign q_push_addr_o = up_req_i.addr;

    // The search sees the queue before this push lands, so a request never hits itself
    assign q_search_o      = up_req_valid_i;
    assign q_search_addr_o = up_req_i.addr;
    assign q_search_mask_o = LINE_MASK;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dn_req_valid_q <= 1'b0;
        end else begin
            dn_req_valid_q <= up_req_valid_i;
        end
    end

    // Payload is captured with its hazard flag and only qualified by the valid bit
    always_ff @(posedge clk_i) begin
        if (up_req_valid_i) begin
            dn_req_q <= '{id: up_req_i.id, addr: up_req_i.addr, hazard: q_hit_i};
        end
    end

    assign dn_req_valid_o = dn_req_valid_q;
    assign dn_req_o       = dn_req_q;

    // Credit accounting upstream must guarantee room in the queue for every request
    a_push_granted: assert property (@(posedge clk_i) disable iff (!rst_ni)
        up_req_valid_i |-> q_push_gnt_i)
        else $error("req_admit request arrived without a free queue entry");

endmodule

// ==== source/id_queue.sv ====
// Per-ID FIFO of addresses with push, popping lookup and masked search ports; used by the tracker
`timescale 1ns/1ps

module id_queue #(
    parameter int CAPACITY = 8,
    parameter int ID_WIDTH = 4
) (
    input  logic            clk_i,
    input  logic            rst_ni,

    input  txn_pkg::id_t    inp_id_i,
    input  txn_pkg::addr_t  inp_data_i,
    input  logic            inp_req_i,
    output logic            inp_gnt_o,

    input  txn_pkg::addr_t  exists_data_i,
    input  txn_pkg::addr_t  exists_mask_i,
    input  logic            exists_req_i,
    output logic            exists_o,
    output logic            exists_gnt_o,

    input  txn_pkg::id_t    oup_id_i,
    input  logic            oup_pop_i,
    input  logic            oup_req_i,
    output txn_pkg::addr_t  oup_data_o,
    output logic            oup_data_valid_o,
    output logic            oup_gnt_o
);

    import txn_pkg::*;

    // There can never be more live IDs than entries, nor more than the ID space allows
    localparam int NUM_IDS  = 2 ** ID_WIDTH;
    localparam int HT_ROWS  = (NUM_IDS < CAPACITY) ? NUM_IDS : CAPACITY;
    localparam int HT_IDX_W = (HT_ROWS > 1) ? $clog2(HT_ROWS) : 1;
    localparam int LD_IDX_W = (CAPACITY > 1) ? $clog2(CAPACITY) : 1;

    typedef logic [HT_IDX_W-1:0] ht_idx_t;
    typedef logic [LD_IDX_W-1:0] ld_idx_t;

    // One row per live ID, pointing at the oldest and the newest entry of that ID
    typedef struct packed {
        id_t     id;
        ld_idx_t head;
        ld_idx_t tail;
    } ht_entry_t;

    // Head-tail table; a row is in use when its free flag is low
    ht_entry_t [HT_ROWS-1:0]  ht_q, ht_d;
    logic      [HT_ROWS-1:0]  ht_free_q, ht_free_d;

    // Linked data table; each entry holds an address and the link to the next of its ID
    addr_t     [CAPACITY-1:0] ld_data_q, ld_data_d;
    ld_idx_t   [CAPACITY-1:0] ld_next_q, ld_next_d;
    logic      [CAPACITY-1:0] ld_free_q, ld_free_d;

    ht_idx_t                  ht_free_idx;
    ld_idx_t                  ld_free_idx;
    logic                     ld_any;
    logic                     full;
    logic                     push_en;

    // ID lookup shared by the push and the output port
    id_t                      match_id;
    logic                     match_valid;
    logic      [HT_ROWS-1:0]  id_hit;
    logic                     no_id_match;
    ht_idx_t                  match_idx;
    ld_idx_t                  head_idx;

    logic      [CAPACITY-1:0] exists_match;

    first_free_finder #(
        .WIDTH (HT_ROWS)
    ) i_ht_free (
        .flags_i (ht_free_q),
        .idx_o   (ht_free_idx),
        .any_o   ()
    );

    first_free_finder #(
        .WIDTH (CAPACITY)
    ) i_ld_free (
        .flags_i (ld_free_q),
        .idx_o   (ld_free_idx),
        .any_o   (ld_any)
    );

    // The queue is full once no linked data entry is free
    assign full      = !ld_any;
    assign inp_gnt_o = !full;
    assign push_en   = inp_req_i && !full;

    // Push wins the cycle, the output port only sees the table when nothing is pushed
    assign oup_gnt_o   = !push_en;
    assign match_id    = push_en ? inp_id_i : oup_id_i;
    assign match_valid = push_en || oup_req_i;

    for (genvar i = 0; i < HT_ROWS; i++) begin : gen_id_hit
        assign id_hit[i] = match_valid && !ht_free_q[i] && (ht_q[i].id == match_id);
    end
    assign no_id_match = !(|id_hit);

    // At most one row holds a given ID, so OR-ing the indices of hit rows is a onehot decode
    always_comb begin
        match_idx = '0;
        for (int i = 0; i < HT_ROWS; i++) begin
            if (id_hit[i]) begin
                match_idx = match_idx | ht_idx_t'(i);
            end
        end
    end

    // Oldest entry of the matched ID
    assign head_idx = ht_q[match_idx].head;

    always_comb begin
        ht_d             = ht_q;
        ht_free_d        = ht_free_q;
        ld_data_d        = ld_data_q;
        ld_next_d        = ld_next_q;
        ld_free_d        = ld_free_q;
        oup_data_o       = '0;
        oup_data_valid_o = 1'b0;

        if (push_en) begin
            if (no_id_match) begin
                // First entry of this ID opens a new row with head and tail on the new entry
                ht_d[ht_free_idx]      = '{id: inp_id_i, head: ld_free_idx, tail: ld_free_idx};
                ht_free_d[ht_free_idx] = 1'b0;
            end else begin
                // Otherwise the new entry is chained behind the current tail
                ld_next_d[ht_q[match_idx].tail] = ld_free_idx;
                ht_d[match_idx].tail            = ld_free_idx;
            end
            ld_data_d[ld_free_idx] = inp_data_i;
            ld_free_d[ld_free_idx] = 1'b0;
        end else if (oup_req_i && !no_id_match) begin
            oup_data_o       = ld_data_q[head_idx];
            oup_data_valid_o = 1'b1;
            if (oup_pop_i) begin
                ld_free_d[head_idx] = 1'b1;
                // The last entry of an ID releases its row, any other moves the head on
                if (head_idx == ht_q[match_idx].tail) begin
                    ht_free_d[match_idx] = 1'b1;
                end else begin
                    ht_d[match_idx].head = ld_next_q[head_idx];
                end
            end
        end
    end

    // Masked search over all occupied entries, only bits set in the mask are compared
    for (genvar i = 0; i < CAPACITY; i++) begin : gen_exists
        assign exists_match[i] = !ld_free_q[i] &&
                                 (((ld_data_q[i] ^ exists_data_i) & exists_mask_i) == '0);
    end
    assign exists_gnt_o = exists_req_i;
    assign exists_o     = exists_req_i && (|exists_match);

    // Free flags decide which table contents are meaningful
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ht_free_q <= '1;
            ld_free_q <= '1;
        end else begin
            ht_free_q <= ht_free_d;
            ld_free_q <= ld_free_d;
        end
    end

    // Table contents are only read behind a cleared free flag
    always_ff @(posedge clk_i) begin
        ht_q      <= ht_d;
        ld_data_q <= ld_data_d;
        ld_next_q <= ld_next_d;
    end

    // A lookup for an ID that is not queued must leave every entry where it was
    a_no_pop_on_miss: assert property (@(posedge clk_i) disable iff (!rst_ni)
        oup_req_i && oup_gnt_o && no_id_match |=> ld_free_q == $past(ld_free_q))
        else $error("id_queue freed an entry on a lookup without ID match");

    // Upstream credits must keep the requester from pushing into a full queue
    a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        inp_req_i |-> !full)
        else $error("id_queue push while full");

endmodule

// ==== source/first_free_finder.sv ====
// Priority encoder over a flag vector; the ID queue uses it to pick the lowest free table slot
`timescale 1ns/1ps

module first_free_finder #(
    parameter int WIDTH = 8,
    localparam int IDX_WIDTH = (WIDTH > 1) ? $clog2(WIDTH) : 1
) (
    input  logic [WIDTH-1:0]     flags_i,
    output logic [IDX_WIDTH-1:0] idx_o,
    output logic                 any_o
);

    // Scan from the top down so that the lowest set flag is the last one written
    // With no flag set the index stays at zero and any_o tells the caller to ignore it
    always_comb begin
        idx_o = '0;
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (flags_i[i]) begin
                idx_o = IDX_WIDTH'(i);
            end
        end
    end

    // At least one slot is free
    assign any_o = |flags_i;

endmodule

// ==== source/txn_pkg.sv ====
// Shared types for the transaction tracker; imported by every RTL module and by the testbench
package txn_pkg;

    // Transaction ID that upstream attaches to every request
    typedef logic [3:0] id_t;

    // Byte address of a request
    typedef logic [31:0] addr_t;

    // Read data carried back by a response
    typedef logic [31:0] rdata_t;

    // Request as it arrives from the upstream master
    typedef struct packed {
        id_t   id;
        addr_t addr;
    } up_req_t;

    // Request as it leaves towards the memory side
    // The hazard bit marks a request whose line is already outstanding
    typedef struct packed {
        id_t   id;
        addr_t addr;
        logic  hazard;
    } dn_req_t;

    // Response as it comes back from the memory side
    typedef struct packed {
        id_t    id;
        rdata_t rdata;
    } dn_rsp_t;

    // Response as it is returned upstream
    // The address is the one of the request it was paired with
    // Miss is set when no request with this ID was outstanding
    typedef struct packed {
        id_t    id;
        addr_t  addr;
        rdata_t rdata;
        logic   miss;
    } up_rsp_t;

endpackage
